/* rtl/uart_defs.svh */
// Global sizing constants for the UART sample rate, FIFO depth and word widths
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Baud ticks per bit on the line
`define UART_SAMPLES 8

// FIFO address width, 16 entries
`define UART_FIFO_AW 4

// Widest data field in a frame
`define UART_DATA_W 8

// Width of the baud prescaler
`define UART_PRESC_W 16

`endif

/* rtl/uart_cfg_pkg.sv */
// Frame format types shared by the UART transmitter, receiver and top level
`default_nettype none

package uart_cfg_pkg;

    // Parity bit sent after the data bits
    typedef enum logic [1:0] {
        parity_none = 2'd0,     // No parity bit in the frame
        parity_odd  = 2'd1,     // Ones in data plus parity is odd
        parity_even = 2'd2      // Ones in data plus parity is even
    } parity_mode_t;

    // Number of data bits is this code plus 5, so 0 to 3 is valid
    typedef logic [2:0] data_size_t;

    typedef enum logic {
        stop_one = 1'b0,        // Single stop bit
        stop_two = 1'b1         // Two stop bits
    } stop_bits_t;

endpackage : uart_cfg_pkg

`default_nettype wire

/* rtl/uart_data_pkg.sv */
// Payload types carried through the UART transmit and receive FIFOs
`default_nettype none
`include "uart_defs.svh"

package uart_data_pkg;

    // One data field, LSB is the first bit on the line
    typedef logic [`UART_DATA_W-1:0] data_word_t;

    // Received word with its error status, stored per entry in the RX FIFO
    typedef struct packed {
        data_word_t data;           // Right aligned, upper bits zero
        logic       parity_error;   // Parity bit disagreed with the data
        logic       frame_error;    // A stop bit was sampled low
    } rx_word_t;

endpackage : uart_data_pkg

`default_nettype wire

/* rtl/uart_fifo.sv */
// Synchronous first-word fall-through FIFO for any payload type
`timescale 1ns/100ps
`default_nettype none

module uart_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  depth_log2 = 4
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    localparam int depth = 1 << depth_log2;

    payload_t              mem [depth];
    logic [depth_log2:0]   wr_ptr;     // Extra MSB tells full from empty
    logic [depth_log2:0]   rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;    // Write on a full FIFO is lost
    assign do_pop  = pop && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[depth_log2] != rd_ptr[depth_log2]) &&
                   (wr_ptr[depth_log2-1:0] == rd_ptr[depth_log2-1:0]);

    // Head entry is visible without a read cycle
    assign pop_data = mem[rd_ptr[depth_log2-1:0]];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[depth_log2-1:0]] <= push_data;
        end
    end

endmodule : uart_fifo

`default_nettype wire

/* rtl/uart_tx.sv */
// UART serializer that sends one FIFO word as a start, data, parity and stop frame
`timescale 1ns/100ps
`default_nettype none
`include "uart_defs.svh"

module uart_tx
    import uart_cfg_pkg::*;
    import uart_data_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         baud_tick,
    input  data_size_t   data_size,
    input  parity_mode_t parity_mode,
    input  stop_bits_t   stop_bits,
    input  logic         fifo_empty,
    input  data_word_t   fifo_data,
    output logic         fifo_pop,
    output logic         tx
);

    localparam int tick_w = $clog2(`UART_SAMPLES);
    localparam logic [tick_w-1:0] tick_last = tick_w'(`UART_SAMPLES - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop0,
        st_stop1
    } state_t;

    state_t            state;
    logic [tick_w-1:0] tick_cnt;       // Ticks within the current bit
    logic [2:0]        bit_cnt;        // Data bit being sent
    data_word_t        shift_reg;
    logic              par_bit;
    logic [3:0]        n_bits;
    data_word_t        masked;
    logic              bit_end;
    logic              last_data;

    assign n_bits    = 4'(data_size) + 4'd5;
    assign masked    = fifo_data & ~({`UART_DATA_W{1'b1}} << n_bits); // Unused bits out of parity
    assign fifo_pop  = (state == st_idle) && !fifo_empty && baud_tick;  // Frame starts on a tick
    assign bit_end   = baud_tick && (tick_cnt == tick_last);
    assign last_data = (bit_cnt == data_size + 3'd4);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;                   // Line idles high
        end else begin
            if (baud_tick && state != st_idle) begin
                tick_cnt <= tick_cnt + 1'b1;    // Wraps once per bit
            end
            case (state)
                st_idle: begin
                    if (fifo_pop) begin
                        state    <= st_start;
                        tick_cnt <= '0;
                        tx       <= 1'b0;       // Start bit
                    end
                end
                st_start: begin
                    if (bit_end) begin
                        state   <= st_data;
                        bit_cnt <= '0;
                        tx      <= shift_reg[0];
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        if (!last_data) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shift_reg[0];
                        end else if (parity_mode == parity_none) begin
                            state <= st_stop0;
                            tx    <= 1'b1;
                        end else begin
                            state <= st_parity;
                            tx    <= par_bit;
                        end
                    end
                end
                st_parity: begin
                    if (bit_end) begin
                        state <= st_stop0;
                        tx    <= 1'b1;
                    end
                end
                st_stop0: begin
                    if (bit_end) begin
                        state <= (stop_bits == stop_two) ? st_stop1 : st_idle;
                    end
                end
                st_stop1: begin
                    if (bit_end) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Word and its parity are taken together from the FIFO head
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            shift_reg <= fifo_data;
            par_bit   <= (parity_mode == parity_odd) ? ~^masked : ^masked;
        end else if (bit_end && (state == st_start || state == st_data)) begin
            shift_reg <= shift_reg >> 1;        // Next bit into position 0
        end
    end

endmodule : uart_tx

`default_nettype wire

/* rtl/uart_rx.sv */
// UART deserializer that samples each bit mid-way and checks parity and stop bits
`timescale 1ns/100ps
`default_nettype none
`include "uart_defs.svh"

module uart_rx
    import uart_cfg_pkg::*;
    import uart_data_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         baud_tick,
    input  data_size_t   data_size,
    input  parity_mode_t parity_mode,
    input  stop_bits_t   stop_bits,
    input  logic         rx,
    output logic         word_valid,
    output rx_word_t     word
);

    localparam int tick_w = $clog2(`UART_SAMPLES);
    localparam logic [tick_w-1:0] tick_last = tick_w'(`UART_SAMPLES - 1);
    localparam logic [tick_w-1:0] tick_half = tick_w'(`UART_SAMPLES / 2 - 1);
    localparam logic [2:0]        max_code  = 3'(`UART_DATA_W - 5);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop0,
        st_stop1
    } state_t;

    state_t            state;
    logic [tick_w-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    data_word_t        shift_reg;      // Fills from the MSB end
    data_word_t        aligned;
    logic              par_acc;        // Running XOR of received data bits
    logic              par_err;
    logic              frm_err;
    logic              sample;
    logic              last_data;

    assign sample    = baud_tick && (tick_cnt == tick_last);
    assign last_data = (bit_cnt == data_size + 3'd4);
    assign aligned   = shift_reg >> (max_code - data_size);  // Right align, zero fill

    assign word = '{data: aligned, parity_error: par_err, frame_error: frm_err};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= st_idle;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            par_acc    <= 1'b0;
            par_err    <= 1'b0;
            frm_err    <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (baud_tick && state != st_idle) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                st_idle: begin
                    if (baud_tick && !rx) begin
                        state    <= st_start;
                        tick_cnt <= '0;
                        par_acc  <= 1'b0;
                        par_err  <= 1'b0;   // Flags live for one frame
                        frm_err  <= 1'b0;
                    end
                end
                st_start: begin
                    if (baud_tick && tick_cnt == tick_half) begin
                        tick_cnt <= '0;     // Later samples fall mid-bit
                        bit_cnt  <= '0;
                        state    <= rx ? st_idle : st_data;  // High here is a glitch
                    end
                end
                st_data: begin
                    if (sample) begin
                        par_acc <= par_acc ^ rx;
                        if (!last_data) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end else begin
                            state <= (parity_mode == parity_none) ? st_stop0 : st_parity;
                        end
                    end
                end
                st_parity: begin
                    if (sample) begin
                        par_err <= (par_acc ^ rx) != (parity_mode == parity_odd);
                        state   <= st_stop0;
                    end
                end
                st_stop0: begin
                    if (sample) begin
                        if (!rx) begin
                            frm_err <= 1'b1;
                        end
                        if (stop_bits == stop_two) begin
                            state <= st_stop1;
                        end else begin
                            state      <= st_idle;
                            word_valid <= 1'b1;
                        end
                    end
                end
                st_stop1: begin
                    if (sample) begin
                        if (!rx) begin
                            frm_err <= 1'b1;
                        end
                        state      <= st_idle;
                        word_valid <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && sample) begin
            shift_reg <= {rx, shift_reg[`UART_DATA_W-1:1]};  // LSB first on the line
        end
    end

endmodule : uart_rx

`default_nettype wire

/* rtl/uart_top.sv */
// UART top level with baud generator, RX synchronizer, loopback and both FIFO paths
`timescale 1ns/100ps
`default_nettype none
`include "uart_defs.svh"

module uart_top
    import uart_cfg_pkg::*;
    import uart_data_pkg::*;
(
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     en,
    input  logic [`UART_PRESC_W-1:0] prescaler,
    input  data_size_t               data_size,
    input  parity_mode_t             parity_mode,
    input  stop_bits_t               stop_bits,
    input  logic                     loopback_en,
    input  logic                     wr,
    input  data_word_t               wdata,
    output logic                     tx_full,
    output logic                     tx_empty,
    input  logic                     rd,
    output data_word_t               rdata,
    output logic                     rx_parity_error,
    output logic                     rx_frame_error,
    output logic                     rx_empty,
    output logic                     rx_full,
    input  logic                     rx,
    output logic                     tx
);

    logic [`UART_PRESC_W-1:0] presc_cnt;
    logic                     baud_tick;
    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_line;
    logic                     tx_pop;
    data_word_t               tx_head;
    logic                     rx_push;
    rx_word_t                 rx_word;
    rx_word_t                 rx_head;

    // Baud tick every prescaler+1 clocks, frozen while disabled
    assign baud_tick = en && (presc_cnt == prescaler);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            presc_cnt <= '0;
        end else if (en) begin
            presc_cnt <= (presc_cnt == prescaler) ? '0 : presc_cnt + 1'b1;
        end
    end

    // Two flops on the asynchronous RX pin, idle level is high
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign rx_line = loopback_en ? tx : rx_sync;    // Internal loopback

    uart_fifo #(
        .payload_t  (data_word_t),
        .depth_log2 (`UART_FIFO_AW)
    ) u_tx_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .push      (wr),
        .push_data (wdata),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .empty     (tx_empty),
        .full      (tx_full)
    );

    uart_tx u_tx (
        .clk         (clk),
        .resetn      (resetn),
        .baud_tick   (baud_tick),
        .data_size   (data_size),
        .parity_mode (parity_mode),
        .stop_bits   (stop_bits),
        .fifo_empty  (tx_empty),
        .fifo_data   (tx_head),
        .fifo_pop    (tx_pop),
        .tx          (tx)
    );

    uart_rx u_rx (
        .clk         (clk),
        .resetn      (resetn),
        .baud_tick   (baud_tick),
        .data_size   (data_size),
        .parity_mode (parity_mode),
        .stop_bits   (stop_bits),
        .rx          (rx_line),
        .word_valid  (rx_push),
        .word        (rx_word)
    );

    uart_fifo #(
        .payload_t  (rx_word_t),
        .depth_log2 (`UART_FIFO_AW)
    ) u_rx_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .push      (rx_push),
        .push_data (rx_word),
        .pop       (rd),
        .pop_data  (rx_head),
        .empty     (rx_empty),
        .full      (rx_full)
    );

    // Head entry split out for the host
    assign rdata           = rx_head.data;
    assign rx_parity_error = rx_head.parity_error;
    assign rx_frame_error  = rx_head.frame_error;

endmodule : uart_top

`default_nettype wire

/* tests/tb_uart.sv */
// Testbench for the UART with loopback, line-level and FIFO checks against a frame model
`timescale 1ns/100ps
`default_nettype none
`include "uart_defs.svh"

module tb_uart
    import uart_cfg_pkg::*;
    import uart_data_pkg::*;
();

    localparam int wait_limit = 2000;   // Clocks allowed for any single wait

    logic                     clk;
    logic                     resetn;
    logic                     en;
    logic [`UART_PRESC_W-1:0] prescaler;
    data_size_t               data_size;
    parity_mode_t             parity_mode;
    stop_bits_t               stop_bits;
    logic                     loopback_en;
    logic                     wr;
    data_word_t               wdata;
    logic                     tx_full;
    logic                     tx_empty;
    logic                     rd;
    data_word_t               rdata;
    logic                     rx_parity_error;
    logic                     rx_frame_error;
    logic                     rx_empty;
    logic                     rx_full;
    logic                     rx;
    logic                     tx;

    int         errors;
    int         checks;
    int         tests;
    data_word_t expq[$];                // Words in flight, oldest first

    uart_top i_uart_top (
        .clk(clk), .resetn(resetn), .en(en), .prescaler(prescaler),
        .data_size(data_size), .parity_mode(parity_mode), .stop_bits(stop_bits),
        .loopback_en(loopback_en), .wr(wr), .wdata(wdata), .tx_full(tx_full),
        .tx_empty(tx_empty), .rd(rd), .rdata(rdata), .rx_parity_error(rx_parity_error),
        .rx_frame_error(rx_frame_error), .rx_empty(rx_empty), .rx_full(rx_full),
        .rx(rx), .tx(tx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic data_word_t mask_data(input data_word_t d, input data_size_t ds);
        data_word_t m;
        m = '0;
        for (int i = 0; i < int'(ds) + 5; i++) begin
            m[i] = 1'b1;
        end
        return d & m;
    endfunction

    // Bit that brings the count of ones to the wanted oddness
    function automatic logic parity_bit(input data_word_t d, input data_size_t ds,
                                        input parity_mode_t pm);
        int ones;
        ones = $countones(mask_data(d, ds));
        return (pm == parity_odd) ? (ones % 2 == 0) : (ones % 2 == 1);
    endfunction

    function automatic int frame_len(input data_size_t ds, input parity_mode_t pm,
                                     input stop_bits_t sb);
        return 1 + int'(ds) + 5 + ((pm != parity_none) ? 1 : 0) + ((sb == stop_two) ? 2 : 1);
    endfunction

    // Line levels in send order, bit 0 is the start bit
    function automatic logic [15:0] build_frame(input data_word_t d, input data_size_t ds,
                                                input parity_mode_t pm);
        logic [15:0] f;
        int          nb;
        f    = '1;                      // Stop bits and idle are high
        nb   = int'(ds) + 5;
        f[0] = 1'b0;
        for (int i = 0; i < nb; i++) begin
            f[1 + i] = d[i];
        end
        if (pm != parity_none) begin
            f[1 + nb] = parity_bit(d, ds, pm);
        end
        return f;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic set_format(input data_size_t ds, input parity_mode_t pm,
                              input stop_bits_t sb);
        @(posedge clk);
        data_size   <= ds;
        parity_mode <= pm;
        stop_bits   <= sb;
    endtask

    task automatic write_word(input data_word_t d);
        @(posedge clk);
        wr    <= 1'b1;
        wdata <= d;
        @(posedge clk);
        wr    <= 1'b0;
    endtask

    task automatic wait_rx_word(output bit got);
        int n;
        n = 0;
        @(negedge clk);
        while (rx_empty && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        got = !rx_empty;
        if (!got) begin
            $display("Timeout at %0t ns: no received word within %0d clocks", $time, n);
            errors++;
        end
    endtask

    task automatic pop_rx_word();
        @(posedge clk);
        rd <= 1'b1;
        @(posedge clk);
        rd <= 1'b0;
    endtask

    task automatic read_and_check(input data_word_t exp_data, input logic exp_perr,
                                  input logic exp_ferr);
        bit got;
        wait_rx_word(got);
        if (got) begin
            compare("rdata", rdata, exp_data);
            compare("rx_parity_error", rx_parity_error, exp_perr);
            compare("rx_frame_error", rx_frame_error, exp_ferr);
            pop_rx_word();
        end
    endtask

    // Each level is held for one bit time of 16 clocks
    task automatic drive_frame(input logic [15:0] f, input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            rx <= f[i];
            repeat (15) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("Test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "failed",
                 errors - err0);
    endtask

    initial begin
        int           err0;
        int           len;
        int           n;
        data_word_t   w;
        data_size_t   ds;
        parity_mode_t pm;
        stop_bits_t   sb;
        logic [15:0]  frame;

        void'($urandom(32'h44f5bf76));
        errors = 0;
        checks = 0;
        tests  = 0;
        resetn      <= 1'b0;
        en          <= 1'b0;
        prescaler   <= `UART_PRESC_W'(1);   // One bit is 16 clocks
        data_size   <= 3'd3;
        parity_mode <= parity_none;
        stop_bits   <= stop_one;
        loopback_en <= 1'b0;
        wr          <= 1'b0;
        wdata       <= '0;
        rd          <= 1'b0;
        rx          <= 1'b1;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;

        err0 = errors;
        @(negedge clk);
        compare("tx after reset", tx, 1'b1);
        compare("tx_empty after reset", tx_empty, 1'b1);
        compare("rx_empty after reset", rx_empty, 1'b1);
        compare("tx_full after reset", tx_full, 1'b0);
        compare("rx_full after reset", rx_full, 1'b0);
        report_test("reset state", err0);

        err0 = errors;
        @(posedge clk);
        en          <= 1'b1;
        loopback_en <= 1'b1;
        for (int d = 0; d < 4; d++) begin
            for (int p = 0; p < 3; p++) begin
                for (int s = 0; s < 2; s++) begin
                    set_format(data_size_t'(d), parity_mode_t'(p), stop_bits_t'(s));
                    for (int k = 0; k < 3; k++) begin
                        w = data_word_t'($urandom);
                        expq.push_back(mask_data(w, data_size_t'(d)));
                        write_word(w);
                    end
                    while (expq.size() > 0) begin
                        read_and_check(expq.pop_front(), 1'b0, 1'b0);
                    end
                    repeat (64) @(posedge clk);     // Let the last stop bit finish
                end
            end
        end
        report_test("loopback all formats", err0);

        err0 = errors;
        @(posedge clk);
        loopback_en <= 1'b0;
        for (int k = 0; k < 4; k++) begin
            ds    = data_size_t'($urandom_range(3, 0));
            pm    = parity_mode_t'($urandom_range(2, 0));
            sb    = stop_bits_t'($urandom_range(1, 0));
            w     = data_word_t'($urandom);
            frame = build_frame(w, ds, pm);
            len   = frame_len(ds, pm, sb);
            set_format(ds, pm, sb);
            write_word(w);
            n = 0;
            @(negedge clk);
            while (tx && n < wait_limit) begin
                @(negedge clk);
                n++;
            end
            if (tx) begin
                $display("Timeout at %0t ns: no start bit on tx", $time);
                errors++;
            end else begin
                repeat (8) @(negedge clk);          // Centre of the start bit
                for (int i = 0; i < len; i++) begin
                    compare($sformatf("tx frame bit %0d", i), tx, frame[i]);
                    repeat (16) @(negedge clk);
                end
            end
            repeat (32) @(posedge clk);
        end
        report_test("frame on tx", err0);

        err0 = errors;
        for (int k = 0; k < 2; k++) begin
            ds    = data_size_t'($urandom_range(3, 0));
            pm    = parity_mode_t'($urandom_range(2, 1));
            sb    = stop_bits_t'($urandom_range(1, 0));
            w     = data_word_t'($urandom);
            frame = build_frame(w, ds, pm);
            frame[int'(ds) + 6] = ~frame[int'(ds) + 6];  // Corrupt the parity bit
            set_format(ds, pm, sb);
            drive_frame(frame, frame_len(ds, pm, sb));
            read_and_check(mask_data(w, ds), 1'b1, 1'b0);
            repeat (32) @(posedge clk);
        end
        report_test("parity error", err0);

        err0 = errors;
        ds    = data_size_t'($urandom_range(3, 0));
        w     = data_word_t'($urandom);
        frame = build_frame(w, ds, parity_none);
        len   = frame_len(ds, parity_none, stop_one);
        frame[len - 1] = 1'b0;                  // Stop bit held low
        set_format(ds, parity_none, stop_one);
        drive_frame(frame, len);
        read_and_check(mask_data(w, ds), 1'b0, 1'b1);
        repeat (400) @(posedge clk);
        @(negedge clk);
        compare("rx_empty after frame error", rx_empty, 1'b1);
        report_test("frame error", err0);

        err0 = errors;
        set_format(3'd3, parity_none, stop_one);
        @(posedge clk);
        en          <= 1'b0;
        loopback_en <= 1'b1;
        // No ticks while disabled, so the transmitter leaves all sixteen in the FIFO
        for (int k = 0; k < 16; k++) begin
            w = data_word_t'($urandom);
            expq.push_back(w);
            write_word(w);
            @(negedge clk);
            compare($sformatf("tx_full after write %0d", k + 1), tx_full, k == 15);
        end
        write_word(data_word_t'($urandom));    // Dropped
        @(negedge clk);
        compare("tx_full after dropped write", tx_full, 1'b1);
        @(posedge clk);
        en <= 1'b1;
        while (expq.size() > 0) begin
            read_and_check(expq.pop_front(), 1'b0, 1'b0);
        end
        repeat (400) @(posedge clk);
        @(negedge clk);
        compare("rx_empty after last word", rx_empty, 1'b1);
        compare("tx_empty after last word", tx_empty, 1'b1);
        report_test("fifo flags", err0);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_uart

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/uart_cfg_pkg.sv
rtl/uart_data_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
tests/tb_uart.sv

/* Makefile */
# Verilator build and run of the UART testbench
TOP = tb_uart

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for a pass"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
